/* BsrBusPort.sv */
`timescale 1ns/1ps

module BsrBusPort
	import BsrCoreDefs::*;
(
	input logic clock,
	input logic reset,
	input BsrWbReq wbReq,
	input logic [31:0] regValRn,
	output logic wbAck,
	output logic [31:0] wbDatR,
	output BsrIssue issue,
	output BsrRegId readId,
	output logic regExHold
);

	logic regRegion;
	logic reqSeen;
	logic acceptWr;
	logic acceptRd;

	assign regRegion = wbReq.adr[kRegRegionBit];

	// Only the register region holds readable ids
	assign readId = regRegion ? BsrRegId'(wbReq.adr[7:2]) : RegZzr;

	// No new request while acking the previous one
	assign reqSeen = wbReq.cyc && wbReq.stb && !wbAck;
	assign acceptWr = reqSeen && wbReq.we;
	assign acceptRd = reqSeen && !wbReq.we && !issue.valid;	// Wait for the entry

	// Special registers only advance for an issued instruction
	assign regExHold = !(issue.valid && !issue.isRegWrite);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wbAck <= 1'b0;
			issue.valid <= 1'b0;
		end
		else
		begin
			wbAck <= acceptWr || acceptRd;
			issue.valid <= acceptWr;		// Entry lives one cycle
		end

		if (acceptWr)
		begin
			issue.isRegWrite <= regRegion;
			issue.regId <= BsrRegId'(wbReq.adr[7:2]);
			issue.payload <= wbReq.datW;
		end

		if (acceptRd)
			wbDatR <= regValRn;
	end

	// Master drops stb in the cycle after ack
	stbDrop: assert property (@(posedge clock) disable iff (reset)
		wbAck |=> !wbReq.stb);

endmodule

/* BsrCoreDefs.sv */
package BsrCoreDefs;

	// Register ids as seen by the Rm/Rn/Ro ports
	typedef enum logic [5:0] {
		RegR0 = 6'd0, RegR1 = 6'd1, RegR2 = 6'd2, RegR3 = 6'd3,
		RegR4 = 6'd4, RegR5 = 6'd5, RegR6 = 6'd6, RegR7 = 6'd7,
		RegR8 = 6'd8, RegR9 = 6'd9, RegR10 = 6'd10, RegR11 = 6'd11,
		RegR12 = 6'd12, RegR13 = 6'd13, RegR14 = 6'd14,
		RegR15 = 6'd15,			// SP
		RegPc = 6'd16, RegLr = 6'd17, RegSr = 6'd18, RegVbr = 6'd19,
		RegDlr = 6'd20, RegDhr = 6'd21, RegGbr = 6'd22, RegTbr = 6'd23,
		RegR0B = 6'd24, RegR1B = 6'd25, RegR2B = 6'd26, RegR3B = 6'd27,
		RegR4B = 6'd28, RegR5B = 6'd29, RegR6B = 6'd30, RegR7B = 6'd31,
		RegSpc = 6'd32, RegSlr = 6'd33, RegSsr = 6'd34, RegSsp = 6'd35,
		RegSdl = 6'd36, RegSdh = 6'd37, RegSgb = 6'd38, RegStb = 6'd39,
		RegImm = 6'd62,			// Read only, decoded immediate
		RegZzr = 6'd63			// Read only, always zero
	} BsrRegId;

	typedef enum logic [5:0] {
		OpAdd = 6'd0,
		OpSub = 6'd1,
		OpAnd = 6'd2,
		OpOr = 6'd3,
		OpXor = 6'd4,
		OpMov = 6'd5,
		OpShl = 6'd6,
		OpCmpEq = 6'd7
	} BsrOpcode;

	typedef struct packed {
		BsrOpcode opcode;		// 31:26
		BsrRegId ro;			// 25:20
		BsrRegId rm;			// 19:14
		BsrRegId rn;			// 13:8
		logic [7:0] imm8;		// Sign extended on IMM reads
	} BsrInsn;

	typedef struct packed {
		logic valid;
		logic isRegWrite;		// Bus register write, not an instruction
		BsrRegId regId;
		logic [31:0] payload;	// Instruction word or write data
	} BsrIssue;

	typedef struct packed {
		logic [31:0] sp;
		logic [31:0] pc;
		logic [31:0] pr;
		logic [31:0] sr;
		logic [31:0] vbr;
		logic [31:0] dlr;
		logic [31:0] dhr;
		logic [31:0] gbr;
		logic [31:0] tbr;
	} BsrSprState;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [9:0] adr;		// Byte address
		logic [31:0] datW;
	} BsrWbReq;

	localparam int kSrRbBit = 29;		// Register bank select in SR
	localparam int kSrTBit = 0;
	localparam logic [31:0] kPcStep = 32'd2;
	localparam int kRegRegionBit = 8;	// Set selects register access

endpackage

/* BsrDecode.sv */
`timescale 1ns/1ps

module BsrDecode
	import BsrCoreDefs::*;
(
	input BsrIssue issue,
	input BsrRegId readId,
	output BsrRegId regIdRm,
	output BsrRegId regIdRn,
	output BsrRegId regIdRo,
	output BsrOpcode op,
	output logic [31:0] imm
);

	BsrInsn insn;

	assign insn = BsrInsn'(issue.payload);

	always_comb
	begin
		if (!issue.valid)
		begin
			// Idle, Rn serves the bus read port
			op = OpMov;
			regIdRm = RegZzr;
			regIdRn = readId;
			regIdRo = RegZzr;
			imm = '0;
		end
		else if (issue.isRegWrite)
		begin
			op = OpMov;					// Full 32-bit value through IMM
			regIdRm = RegImm;
			regIdRn = RegZzr;
			regIdRo = issue.regId;
			imm = issue.payload;
		end
		else
		begin
			op = insn.opcode;
			regIdRm = insn.rm;
			regIdRn = insn.rn;
			regIdRo = insn.ro;
			imm = {{24{insn.imm8[7]}}, insn.imm8};
		end
	end

endmodule

/* BsrExecUnit.f */
BsrCoreDefs.sv
BsrRegGpr.sv
BsrDecode.sv
BsrExecute.sv
BsrBusPort.sv
BsrExecUnit.sv
BsrExecUnitTb.sv

/* BsrExecUnit.sv */
`timescale 1ns/1ps

module BsrExecUnit
	import BsrCoreDefs::*;
(
	input logic clock,
	input logic reset,
	input BsrWbReq wbReq,
	output logic wbAck,
	output logic [31:0] wbDatR,
	output BsrSprState sprOut
);

	BsrIssue issue;
	BsrRegId readId;
	logic regExHold;
	BsrRegId regIdRm;
	BsrRegId regIdRn;
	BsrRegId regIdRo;
	BsrOpcode op;
	logic [31:0] imm;
	logic [31:0] regValRm;
	logic [31:0] regValRn;
	logic [31:0] regValRo;
	BsrSprState sprNext;

	BsrBusPort BsrBusPort_i (
		.clock(clock),
		.reset(reset),
		.wbReq(wbReq),
		.regValRn(regValRn),
		.wbAck(wbAck),
		.wbDatR(wbDatR),
		.issue(issue),
		.readId(readId),
		.regExHold(regExHold)
	);

	BsrDecode BsrDecode_i (
		.issue(issue),
		.readId(readId),
		.regIdRm(regIdRm),
		.regIdRn(regIdRn),
		.regIdRo(regIdRo),
		.op(op),
		.imm(imm)
	);

	BsrRegGpr BsrRegGpr_i (
		.clock(clock),
		.reset(reset),
		.regIdRm(regIdRm),
		.regIdRn(regIdRn),
		.regIdRo(regIdRo),
		.regValRo(regValRo),
		.imm(imm),
		.regExHold(regExHold),
		.sprNext(sprNext),
		.regValRm(regValRm),
		.regValRn(regValRn),
		.sprCur(sprOut)			// Live special registers
	);

	BsrExecute BsrExecute_i (
		.op(op),
		.regValRm(regValRm),
		.regValRn(regValRn),
		.sprCur(sprOut),
		.regIdRo(regIdRo),
		.regValRo(regValRo),
		.sprNext(sprNext)
	);

endmodule

/* BsrExecUnitTb.sv */
`timescale 1ns/1ps

module BsrExecUnitTb
	import BsrCoreDefs::*;
();

	typedef enum logic [1:0] {KindIssue, KindWrite, KindRead} VecKind;

	typedef struct packed {
		VecKind kind;
		BsrRegId id;			// Register id for writes and reads
		logic [31:0] data;		// Instruction word or write data
		logic [31:0] expVal;	// Expected read data
		logic [31:0] expPc;		// Expected sprOut.pc after the entry
		logic [31:0] expSr;
	} Vector;

	localparam int kMaxVectors = 256;

	logic clock;
	logic reset;
	BsrWbReq wbReq;
	logic wbAck;
	logic [31:0] wbDatR;
	BsrSprState sprOut;

	Vector vectors [kMaxVectors];
	int numVectors;
	logic [31:0] model [64];		// Reference registers indexed by id
	integer seed;
	int cycleCount;
	int cycleLimit;

	BsrExecUnit BsrExecUnit_i (
		.clock(clock),
		.reset(reset),
		.wbReq(wbReq),
		.wbAck(wbAck),
		.wbDatR(wbDatR),
		.sprOut(sprOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] modelRead(BsrRegId id, logic [31:0] immVal);
		logic [31:0] val;
		case (id)
			RegPc: val = model[RegPc] + 32'd2;	// Next instruction address
			RegImm: val = immVal;
			RegZzr: val = '0;
			default: val = model[id];			// Unassigned ids stay zero
		endcase
		return val;
	endfunction

	task automatic modelWrite(input BsrRegId id, input logic [31:0] val);
		logic [31:0] tmp;
		if (id < 6'd40)
		begin
			if (id == RegSr && val[kSrRbBit] != model[RegSr][kSrRbBit])
				for (int i = 0; i < 8; i++)
				begin
					tmp = model[i];
					model[i] = model[24 + i];
					model[24 + i] = tmp;
				end
			model[id] = val;
		end
	endtask

	task automatic modelIssue(input logic [31:0] word);
		BsrInsn insn;
		logic [31:0] immVal;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		insn = word;
		immVal = {{24{insn.imm8[7]}}, insn.imm8};
		a = modelRead(insn.rm, immVal);
		b = modelRead(insn.rn, immVal);
		case (insn.opcode)
			OpAdd: res = a + b;
			OpSub: res = a - b;
			OpAnd: res = a & b;
			OpOr: res = a | b;
			OpXor: res = a ^ b;
			OpMov: res = a;
			OpShl: res = a << b[4:0];
			default: res = '0;
		endcase
		model[RegPc] = model[RegPc] + 32'd2;
		if (insn.opcode == OpCmpEq)
			model[RegSr][0] = (a == b);		// T bit
		modelWrite(insn.ro, res);
	endtask

	task automatic storeVector(input VecKind kind, input BsrRegId id,
		input logic [31:0] data, input logic [31:0] expVal);
		vectors[numVectors].kind = kind;
		vectors[numVectors].id = id;
		vectors[numVectors].data = data;
		vectors[numVectors].expVal = expVal;
		vectors[numVectors].expPc = model[RegPc];
		vectors[numVectors].expSr = model[RegSr];
		numVectors++;
	endtask

	task automatic writeVector(input BsrRegId id, input logic [31:0] val);
		modelWrite(id, val);
		storeVector(KindWrite, id, val, '0);
	endtask

	task automatic readVector(input BsrRegId id);
		storeVector(KindRead, id, '0, modelRead(id, '0));	// IMM is zero when idle
	endtask

	task automatic issueVector(input BsrOpcode op, input BsrRegId ro, input BsrRegId rm,
		input BsrRegId rn, input logic [7:0] imm8);
		logic [31:0] word;
		word = {op, ro, rm, rn, imm8};
		modelIssue(word);
		storeVector(KindIssue, RegZzr, word, '0);
	endtask

	task automatic buildTable();
		for (int i = 0; i < 64; i++)
			model[i] = '0;
		numVectors = 0;
		for (int i = 16; i < 24; i++)
			readVector(BsrRegId'(i));		// Specials after reset
		for (int i = 0; i < 16; i++)
			writeVector(BsrRegId'(i), $random(seed));
		writeVector(RegVbr, $random(seed));
		writeVector(RegGbr, $random(seed));
		for (int i = 24; i < 40; i++)
			writeVector(BsrRegId'(i), $random(seed));	// Bank B and shadows
		for (int i = 0; i < 16; i++)
			readVector(BsrRegId'(i));
		readVector(RegVbr);
		readVector(RegGbr);
		for (int i = 24; i < 40; i++)
			readVector(BsrRegId'(i));
		writeVector(RegImm, $random(seed));
		writeVector(RegZzr, $random(seed));
		readVector(RegZzr);
		readVector(RegImm);
		readVector(BsrRegId'(6'd45));		// Unassigned id

		writeVector(RegR1, 32'h8000_00f3);
		writeVector(RegR2, 32'h0000_0007);
		for (int i = 0; i < 7; i++)
		begin
			issueVector(BsrOpcode'(i), BsrRegId'(3 + i), RegR1, RegR2, 8'h00);
			readVector(BsrRegId'(3 + i));
		end
		issueVector(OpAdd, RegR10, RegR1, RegImm, 8'hf6);	// Negative imm8
		readVector(RegR10);
		issueVector(OpSub, RegR11, RegR2, RegImm, 8'h80);
		readVector(RegR11);
		issueVector(OpMov, RegR12, RegPc, RegZzr, 8'h00);
		readVector(RegR12);
		issueVector(OpCmpEq, RegZzr, RegR1, RegR2, 8'h00);
		readVector(RegSr);
		issueVector(OpCmpEq, RegZzr, RegR1, RegR1, 8'h00);
		readVector(RegSr);
		issueVector(OpCmpEq, RegZzr, RegR2, RegImm, 8'h07);
		readVector(RegSr);
		issueVector(OpCmpEq, RegZzr, RegR1, RegImm, 8'hf3);	// Differs after sign extension
		readVector(RegSr);
		readVector(RegPc);

		for (int i = 0; i < 8; i++)
			writeVector(BsrRegId'(i), $random(seed));
		writeVector(RegSr, model[RegSr] ^ 32'h2000_0000);	// Flip RB
		for (int i = 0; i < 8; i++)
			readVector(BsrRegId'(i));
		for (int i = 24; i < 32; i++)
			readVector(BsrRegId'(i));
		issueVector(OpAdd, RegR0, RegR0, RegR1, 8'h00);
		readVector(RegR0);
		readVector(RegR0B);
		writeVector(RegSr, model[RegSr] ^ 32'h2000_0000);
		for (int i = 0; i < 8; i++)
			readVector(BsrRegId'(i));
		for (int i = 24; i < 32; i++)
			readVector(BsrRegId'(i));

		for (int i = 0; i < 3; i++)
		begin
			issueVector(OpAdd, RegR4, RegR4, RegImm, 8'(5 + i));
			readVector(RegR4);				// Same register right after
		end
		issueVector(OpMov, RegR5, RegPc, RegZzr, 8'h00);
		readVector(RegR5);
	endtask

	task automatic compareValue(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s, expected %h, got %h", $time, what, exp, got);
			$display("sim failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Classic cycle, waits for ack with no fixed latency
	task automatic busCycle(input logic we, input logic [9:0] adr, input logic [31:0] dat,
		output logic [31:0] rdat);
		@(posedge clock);
		wbReq.cyc <= 1'b1;
		wbReq.stb <= 1'b1;
		wbReq.we <= we;
		wbReq.adr <= adr;
		wbReq.datW <= dat;
		@(negedge clock);
		while (!wbAck)
			@(negedge clock);
		rdat = wbDatR;
		@(posedge clock);
		wbReq <= '0;					// Drop stb after ack
	endtask

	task automatic applyVector(input int idx);
		Vector v;
		logic [9:0] adr;
		logic [31:0] rdat;
		v = vectors[idx];
		adr = (v.kind == KindIssue) ? 10'h000 : {2'b01, v.id, 2'b00};
		busCycle(v.kind != KindRead, adr, v.data, rdat);
		@(negedge clock);
		if (v.kind == KindRead)
			compareValue($sformatf("entry %0d read of id %0d", idx, v.id), rdat, v.expVal);
		compareValue($sformatf("entry %0d sprOut.pc", idx), sprOut.pc, v.expPc);
		compareValue($sformatf("entry %0d sprOut.sr", idx), sprOut.sr, v.expSr);
	endtask

	initial
	begin
		cycleCount = 0;
		@(posedge clock);
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: bus traffic did not finish within %0d cycles", cycleLimit);
		$display("sim failed");
		$fatal(1, "Run aborted by watchdog");
	end

	initial
	begin
		wbReq = '0;
		reset = 1'b1;
		seed = 32'h06ed_e253;
		buildTable();
		cycleLimit = numVectors * 20 + 16;	// Reset plus margin
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		for (int i = 0; i < 9; i++)
			compareValue($sformatf("sprOut word %0d after reset", i), sprOut[32 * i +: 32], '0);
		for (int i = 0; i < numVectors; i++)
			applyVector(i);
		$display("sim passed");
		$finish;
	end

endmodule

/* BsrExecute.sv */
`timescale 1ns/1ps

module BsrExecute
	import BsrCoreDefs::*;
(
	input BsrOpcode op,
	input logic [31:0] regValRm,
	input logic [31:0] regValRn,
	input BsrSprState sprCur,
	input BsrRegId regIdRo,
	output logic [31:0] regValRo,
	output BsrSprState sprNext
);

	logic [31:0] result;
	logic isEqual;

	assign isEqual = regValRm == regValRn;

	always_comb
	begin
		sprNext = sprCur;
		sprNext.pc = sprCur.pc + kPcStep;	// Bank ignores this while held

		case (op)
			OpAdd: result = regValRm + regValRn;
			OpSub: result = regValRm - regValRn;
			OpAnd: result = regValRm & regValRn;
			OpOr: result = regValRm | regValRn;
			OpXor: result = regValRm ^ regValRn;
			OpMov: result = regValRm;
			OpShl: result = regValRm << regValRn[4:0];
			OpCmpEq:
			begin
				result = '0;
				sprNext.sr[kSrTBit] = isEqual;
			end
			default: result = '0;
		endcase
	end

	// Keep the write bus quiet when the target is a pseudo register
	always_comb
	begin
		if (regIdRo inside {RegImm, RegZzr})
			regValRo = '0;
		else
			regValRo = result;
	end

endmodule

/* BsrRegGpr.sv */
`timescale 1ns/1ps

module BsrRegGpr
	import BsrCoreDefs::*;
(
	input logic clock,
	input logic reset,
	input BsrRegId regIdRm,
	input BsrRegId regIdRn,
	input BsrRegId regIdRo,
	input logic [31:0] regValRo,
	input logic [31:0] imm,
	input logic regExHold,
	input BsrSprState sprNext,
	output logic [31:0] regValRm,
	output logic [31:0] regValRn,
	output BsrSprState sprCur
);

	logic [31:0] bankA [8];			// R0..R7 of the active bank
	logic [31:0] bankB [8];			// R0B..R7B
	logic [31:0] gprHi [8:14];		// R8..R14
	logic [31:0] shadow [8];		// SPC..STB
	BsrSprState spr;

	logic [31:0] srNext;
	logic bankSwap;
	logic roBankA;
	logic roBankB;
	logic roHi;
	logic roShadow;
	logic [2:0] roIdx;

	// Shared by both read ports
	function automatic logic [31:0] readReg(BsrRegId id);
		logic [31:0] val;
		case (id) inside
			[RegR0:RegR7]: val = bankA[id[2:0]];
			[RegR8:RegR14]: val = gprHi[id[3:0]];
			RegR15: val = spr.sp;
			RegPc: val = spr.pc + kPcStep;	// Address of the next insn
			RegLr: val = spr.pr;
			RegSr: val = spr.sr;
			RegVbr: val = spr.vbr;
			RegDlr: val = spr.dlr;
			RegDhr: val = spr.dhr;
			RegGbr: val = spr.gbr;
			RegTbr: val = spr.tbr;
			[RegR0B:RegR7B]: val = bankB[id[2:0]];
			[RegSpc:RegStb]: val = shadow[id[2:0]];
			RegImm: val = imm;
			default: val = '0;			// ZZR and unassigned ids
		endcase
		return val;
	endfunction

	// Ro wins over the execute update, which only lands when not held
	function automatic logic [31:0] nextSpr(BsrRegId id, logic [31:0] cur,
		logic [31:0] nxt);
		logic [31:0] val;
		if (regIdRo == id)
			val = regValRo;
		else if (!regExHold)
			val = nxt;
		else
			val = cur;
		return val;
	endfunction

	always_comb
	begin
		regValRm = readReg(regIdRm);
		regValRn = readReg(regIdRn);
	end

	always_comb
	begin
		roIdx = regIdRo[2:0];
		roBankA = regIdRo inside {[RegR0:RegR7]};
		roBankB = regIdRo inside {[RegR0B:RegR7B]};
		roHi = regIdRo inside {[RegR8:RegR14]};
		roShadow = regIdRo inside {[RegSpc:RegStb]};
		srNext = nextSpr(RegSr, spr.sr, sprNext.sr);
		bankSwap = srNext[kSrRbBit] != spr.sr[kSrRbBit];	// RB flips this cycle
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < 8; i++)
		begin
			if (roBankA && roIdx == 3'(i))
				bankA[i] <= regValRo;		// Lands in the new active bank
			else if (bankSwap)
				bankA[i] <= bankB[i];
			if (roBankB && roIdx == 3'(i))
				bankB[i] <= regValRo;
			else if (bankSwap)
				bankB[i] <= bankA[i];
		end
		if (roHi)
			gprHi[regIdRo[3:0]] <= regValRo;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			spr <= '0;
			for (int i = 0; i < 8; i++)
				shadow[i] <= '0;
		end
		else
		begin
			spr.sp <= nextSpr(RegR15, spr.sp, sprNext.sp);
			spr.pc <= nextSpr(RegPc, spr.pc, sprNext.pc);
			spr.pr <= nextSpr(RegLr, spr.pr, sprNext.pr);
			spr.sr <= srNext;
			spr.vbr <= nextSpr(RegVbr, spr.vbr, sprNext.vbr);
			spr.dlr <= nextSpr(RegDlr, spr.dlr, sprNext.dlr);
			spr.dhr <= nextSpr(RegDhr, spr.dhr, sprNext.dhr);
			spr.gbr <= nextSpr(RegGbr, spr.gbr, sprNext.gbr);
			spr.tbr <= nextSpr(RegTbr, spr.tbr, sprNext.tbr);
			if (roShadow)
				shadow[roIdx] <= regValRo;	// Explicit access only
		end
	end

	assign sprCur = spr;

	// Decode must always present a defined target, ZZR when idle
	roKnown: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(regIdRo));

endmodule
